// ==== common/vid_pkg.sv ====
package vid_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int coord_w = 12;        // Pixel coordinates and timing counters

    // ========================================
    // Pixel and bus types
    // ========================================

    // 24-bit pixel as sent to the HDMI transmitter
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Camera pins, pixel clock folded into a byte strobe
    typedef struct packed {
        logic       vsync;              // Frame start, active high
        logic       href;               // Line active
        logic       byte_en;            // One cycle per camera byte
        logic [7:0] data;
    } cam_bus_t;

    // Captured pixel on its way to the frame buffer
    typedef struct packed {
        rgb_t        rgb;
        logic [15:0] addr;              // Pixel index within the frame
        logic        sof;               // First pixel of the frame
        logic        eof;               // Last pixel of the frame
    } cam_pix_t;

    // Raster position and syncs from the timing generator
    typedef struct packed {
        logic               de;
        logic               hs;
        logic               vs;
        logic [coord_w-1:0] x;          // Zero outside the active area
        logic [coord_w-1:0] y;
    } timing_t;

    // Parallel video toward the HDMI transmitter
    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        rgb_t rgb;
    } vid_out_t;

endpackage

// ==== design/cam_capture.sv ====
module cam_capture import vid_pkg::*; #(
    parameter int h_act = 8,
    parameter int v_act = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  cam_bus_t cam,
    output cam_pix_t pix,
    output logic     pix_valid
);

    localparam int          frame_px = h_act * v_act;
    localparam logic [15:0] last_idx = 16'(frame_px - 1);   // Index that carries eof

    logic        phase;         // High once the first byte of a pair is held
    logic [7:0]  hi_byte;       // First byte, upper half of RGB565
    logic [15:0] pix_idx;       // Next pixel index in this frame
    logic        sof_armed;     // Next emitted pixel starts the frame
    logic        frame_done;    // Last pixel already emitted
    logic        byte_hit;      // Camera byte inside an active line
    logic        take;          // Second byte of a pair
    logic [15:0] rgb565;

    assign byte_hit = cam.href && cam.byte_en;
    assign take     = byte_hit && phase;
    assign rgb565   = {hi_byte, cam.data};     // High byte first on the wire

    // ========================================
    // Byte phase and pixel counting
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= 1'b0;
            pix_idx    <= '0;
            sof_armed  <= 1'b0;
            frame_done <= 1'b0;
            pix_valid  <= 1'b0;
        end else if (cam.vsync) begin
            // New frame, start pairing from scratch
            phase      <= 1'b0;
            pix_idx    <= '0;
            sof_armed  <= 1'b1;
            frame_done <= 1'b0;
            pix_valid  <= 1'b0;
        end else begin
            pix_valid <= take && !frame_done;   // One cycle after the second byte
            if (byte_hit)
                phase <= ~phase;
            if (take && !frame_done) begin
                pix_idx    <= pix_idx + 16'd1;
                sof_armed  <= 1'b0;
                frame_done <= (pix_idx == last_idx);  // Drop anything past the frame
            end
        end
    end

    // ========================================
    // Pixel payload
    // ========================================
    always_ff @(posedge clk) begin
        if (byte_hit && !phase)
            hi_byte <= cam.data;
        if (take) begin
            // Widen each channel by repeating its top bits
            pix.rgb.r <= {rgb565[15:11], rgb565[15:13]};
            pix.rgb.g <= {rgb565[10:5], rgb565[10:9]};
            pix.rgb.b <= {rgb565[4:0], rgb565[4:2]};
            pix.addr  <= pix_idx;
            pix.sof   <= sof_armed;
            pix.eof   <= (pix_idx == last_idx);
        end
    end

endmodule

// ==== design/frame_ctrl.sv ====
module frame_ctrl import vid_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  cam_pix_t pix,
    input  logic     pix_valid,
    input  logic     frame_start,   // First cycle of display vsync
    output logic     pix_ready,
    output logic     wr_bank,
    output logic     rd_bank,
    output logic     shown          // Some frame has reached the display
);

    // Capture side of the double buffer
    typedef enum logic [1:0] {
        st_wait_sof,                // Hunting for the start of a frame
        st_fill,                    // Writing the current frame
        st_full                     // Frame complete, waiting for vsync
    } state_t;

    state_t state;
    logic   bank;                   // Bank currently written by the camera
    logic   fire;                   // Pixel accepted this cycle

    // ========================================
    // Write acceptance
    // ========================================
    always_comb begin
        case (state)
            st_wait_sof: pix_ready = pix_valid && pix.sof;  // Only a frame start gets in
            st_fill:     pix_ready = 1'b1;
            default:     pix_ready = 1'b0;                  // Camera pixels are dropped
        endcase
    end

    assign fire = pix_valid && pix_ready;

    // ========================================
    // Bank FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_wait_sof;
            bank  <= 1'b0;
            shown <= 1'b0;
        end else begin
            case (state)
                st_wait_sof: begin
                    if (fire)
                        state <= pix.eof ? st_full : st_fill;   // One-pixel frame edge case
                end
                st_fill: begin
                    // A fresh sof simply rewrites the same bank from address 0
                    if (fire && pix.eof)
                        state <= st_full;
                end
                st_full: begin
                    if (frame_start) begin
                        bank  <= ~bank;     // Completed frame becomes the read bank
                        shown <= 1'b1;
                        state <= st_wait_sof;
                    end
                end
                default: state <= st_wait_sof;
            endcase
        end
    end

    assign wr_bank = bank;
    assign rd_bank = ~bank;         // Always the other bank

endmodule

// ==== display/video_timing.sv ====
module video_timing import vid_pkg::*; #(
    parameter int h_act  = 8,
    parameter int h_fp   = 1,
    parameter int h_sync = 2,
    parameter int h_bp   = 1,
    parameter int v_act  = 4,
    parameter int v_fp   = 1,
    parameter int v_sync = 1,
    parameter int v_bp   = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    output timing_t tmg,
    output logic    frame_start     // One cycle, aligned with the rise of tmg.vs
);

    localparam int h_total = h_act + h_fp + h_sync + h_bp;
    localparam int v_total = v_act + v_fp + v_sync + v_bp;

    // Counter compare points
    localparam logic [coord_w-1:0] h_last  = coord_w'(h_total - 1);
    localparam logic [coord_w-1:0] v_last  = coord_w'(v_total - 1);
    localparam logic [coord_w-1:0] h_end   = coord_w'(h_act);
    localparam logic [coord_w-1:0] v_end   = coord_w'(v_act);
    localparam logic [coord_w-1:0] hs_beg  = coord_w'(h_act + h_fp);
    localparam logic [coord_w-1:0] hs_end  = coord_w'(h_act + h_fp + h_sync);
    localparam logic [coord_w-1:0] vs_beg  = coord_w'(v_act + v_fp);
    localparam logic [coord_w-1:0] vs_end  = coord_w'(v_act + v_fp + v_sync);

    logic [coord_w-1:0] h_cnt;      // Column within the line
    logic [coord_w-1:0] v_cnt;      // Line within the frame
    logic               de_nx;
    logic               hs_nx;
    logic               vs_nx;

    // ========================================
    // Raster counters
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_last) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign de_nx = (h_cnt < h_end) && (v_cnt < v_end);     // Active area starts at 0,0
    assign hs_nx = (h_cnt >= hs_beg) && (h_cnt < hs_end);
    assign vs_nx = (v_cnt >= vs_beg) && (v_cnt < vs_end);   // Whole lines

    // Registered outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmg         <= '0;
            frame_start <= 1'b0;
        end else begin
            tmg.de      <= de_nx;
            tmg.hs      <= hs_nx;
            tmg.vs      <= vs_nx;
            tmg.x       <= de_nx ? h_cnt : '0;
            tmg.y       <= de_nx ? v_cnt : '0;
            frame_start <= vs_nx && !tmg.vs;    // Rising edge of vs
        end
    end

endmodule

// ==== frame_buffer/frame_buffer.sv ====
module frame_buffer import vid_pkg::*; #(
    parameter int h_act = 8,
    parameter int v_act = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  cam_pix_t pix,
    input  logic     pix_valid,
    input  logic     pix_ready,
    input  logic     wr_bank,
    input  logic     rd_bank,
    input  logic     shown,
    input  timing_t  tmg,
    output vid_out_t vid
);

    localparam int frame_px = h_act * v_act;
    localparam int aw       = (frame_px > 1) ? $clog2(frame_px) : 1;

    rgb_t          bank0 [frame_px];    // On-chip frame banks
    rgb_t          bank1 [frame_px];
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] rd_addr;
    logic          fire;
    rgb_t          rd_q;                // Registered scan-out pixel
    logic          de_q;
    logic          hs_q;
    logic          vs_q;

    assign fire    = pix_valid && pix_ready;
    assign wr_addr = pix.addr[aw-1:0];
    assign rd_addr = aw'(tmg.y * h_act + tmg.x);    // Raster order

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk) begin
        if (fire) begin
            if (wr_bank)
                bank1[wr_addr] <= pix.rgb;
            else
                bank0[wr_addr] <= pix.rgb;
        end
    end

    // ========================================
    // Scan-out port
    // ========================================
    always_ff @(posedge clk) begin
        rd_q <= rd_bank ? bank1[rd_addr] : bank0[rd_addr];
    end

    // Syncs delayed to line up with the read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= tmg.de;
            hs_q <= tmg.hs;
            vs_q <= tmg.vs;
        end
    end

    assign vid.de  = de_q;
    assign vid.hs  = hs_q;
    assign vid.vs  = vs_q;
    assign vid.rgb = (de_q && shown) ? rd_q : '0;   // Black in blanking and before first swap

endmodule

// ==== design/img_cap_top.sv ====
module img_cap_top import vid_pkg::*; #(
    parameter int h_act  = 8,       // Active pixels per line
    parameter int h_fp   = 1,
    parameter int h_sync = 2,
    parameter int h_bp   = 1,
    parameter int v_act  = 4,       // Active lines per frame
    parameter int v_fp   = 1,
    parameter int v_sync = 1,
    parameter int v_bp   = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  cam_bus_t cam,
    output vid_out_t vid
);

    cam_pix_t pix;                  // Capture to frame buffer
    logic     pix_valid;
    logic     pix_ready;
    logic     wr_bank;
    logic     rd_bank;
    logic     shown;
    timing_t  tmg;                  // Raster position for scan-out
    logic     frame_start;          // Bank swap point

    // ========================================
    // Camera side
    // ========================================
    cam_capture #(
        .h_act(h_act),
        .v_act(v_act)
    ) u_cam_capture (
        .clk      (clk),
        .rst_n    (rst_n),
        .cam      (cam),
        .pix      (pix),
        .pix_valid(pix_valid)
    );

    frame_ctrl u_frame_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .frame_start(frame_start),
        .pix_ready  (pix_ready),
        .wr_bank    (wr_bank),
        .rd_bank    (rd_bank),
        .shown      (shown)
    );

    // ========================================
    // Display side
    // ========================================
    video_timing #(
        .h_act(h_act), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
        .v_act(v_act), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
    ) u_video_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .tmg        (tmg),
        .frame_start(frame_start)
    );

    frame_buffer #(
        .h_act(h_act),
        .v_act(v_act)
    ) u_frame_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (pix),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .wr_bank  (wr_bank),
        .rd_bank  (rd_bank),
        .shown    (shown),
        .tmg      (tmg),
        .vid      (vid)
    );

endmodule

// ==== verif/img_cap_asserts.sv ====
module img_cap_asserts (
    input logic clk,
    input logic rst_n,
    input logic pix_valid,
    input logic pix_ready,
    input logic pix_eof,        // Last pixel of the offered frame
    input logic frame_start,
    input logic wr_bank,
    input logic rd_bank,
    input logic shown
);

    logic full_seen;            // Accepted eof still waiting for the display swap
    logic swap_due;             // Bank swap expected at this edge

    assign swap_due = frame_start && full_seen;

    // Completion tracked from the handshake and the vsync pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            full_seen <= 1'b0;
        else if (pix_valid && pix_ready && pix_eof)
            full_seen <= 1'b1;
        else if (frame_start)
            full_seen <= 1'b0;
    end

    // ========================================
    // Bank control rules
    // ========================================
    property no_ready_when_full;
        @(posedge clk) disable iff (!rst_n) full_seen |-> !pix_ready;
    endproperty

    // Banks stay apart and trade places only at a due swap
    property banks_apart;
        @(posedge clk) disable iff (!rst_n)
            (wr_bank != rd_bank) && ((wr_bank != $past(wr_bank)) == $past(swap_due));
    endproperty

    property shown_sticky;
        @(posedge clk) disable iff (!rst_n)
            shown == ($past(shown) || $past(swap_due));    // Set by the first swap only
    endproperty

    a_no_ready_when_full: assert property (no_ready_when_full) else $error("pix_ready in FULL");
    a_banks_apart:        assert property (banks_apart) else $error("bank select wrong");
    a_shown_sticky:       assert property (shown_sticky) else $error("shown wrong");

endmodule

bind frame_ctrl img_cap_asserts u_img_cap_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .pix_eof    (pix.eof),
    .frame_start(frame_start),
    .wr_bank    (wr_bank),
    .rd_bank    (rd_bank),
    .shown      (shown)
);

// ==== verif/img_cap_tb.sv ====
module img_cap_tb import vid_pkg::*; ();

    // Default geometry of img_cap_top
    localparam int h_act     = 8;
    localparam int h_fp      = 1;
    localparam int h_sync    = 2;
    localparam int h_bp      = 1;
    localparam int v_act     = 4;
    localparam int v_fp      = 1;
    localparam int v_sync    = 1;
    localparam int v_bp      = 1;
    localparam int h_total   = h_act + h_fp + h_sync + h_bp;
    localparam int v_total   = v_act + v_fp + v_sync + v_bp;
    localparam int frame_px  = h_act * v_act;
    localparam int max_cases = 16;
    localparam int s_wait    = 0;           // Capture FSM model states
    localparam int s_fill    = 1;
    localparam int s_full    = 2;

    logic     clk;
    logic     rst_n;
    cam_bus_t cam;
    vid_out_t vid;

    logic [15:0] cases [3*max_cases];       // kind, gap, shown per case
    int          n_cases;
    int          limit;                     // Cycle limit worked out from the cases
    int          cycle_cnt;
    int          drv_case;                  // Case id tagged onto each vsync
    integer      seed;

    // Reference model state
    rgb_t        mbank [2][frame_px];
    bit          seen [max_cases];          // Case reached the display
    bit          c_phase;
    bit          c_sof;
    bit          c_done;
    logic [7:0]  c_hi;
    int          c_idx;
    int          cap_id;
    bit          m_valid;                   // Modeled capture output
    rgb_t        m_rgb;
    int          m_addr;
    bit          m_sof;
    bit          m_eof;
    int          m_id;
    int          f_state;
    bit          f_bank;                    // Write bank of the model
    bit          f_shown;
    int          f_fill_id;
    int          swaps;
    int          h_cnt;
    int          v_cnt;
    bit          t_de, t_hs, t_vs, t_fs;    // Modeled timing registers
    int          t_x;
    int          t_y;
    bit          e_de, e_hs, e_vs;          // Modeled scan-out registers
    rgb_t        e_rgb;
    int          fs_count;

    img_cap_top dut (
        .clk  (clk),
        .rst_n(rst_n),
        .cam  (cam),
        .vid  (vid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Reporting and compare tasks
    // ========================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [23:0] exp,
                                   input logic [23:0] act);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        abort_run("output differs from the reference model");
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_sync(input vid_out_t exp, input vid_out_t act);
        if (act.de !== exp.de) report_mismatch("vid.de", 24'(exp.de), 24'(act.de));
        if (act.hs !== exp.hs) report_mismatch("vid.hs", 24'(exp.hs), 24'(act.hs));
        if (act.vs !== exp.vs) report_mismatch("vid.vs", 24'(exp.vs), 24'(act.vs));
    endtask

    // RGB565 to RGB888 by scaling each channel up and refilling its low bits
    function automatic rgb_t expand565(input logic [7:0] hi, input logic [7:0] lo);
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        rgb_t       p;
        r5  = hi[7:3];
        g6  = {hi[2:0], lo[7:5]};
        b5  = lo[4:0];
        p.r = (8'(r5) << 3) | 8'(r5 >> 2);
        p.g = (8'(g6) << 2) | 8'(g6 >> 4);
        p.b = (8'(b5) << 3) | 8'(b5 >> 2);
        return p;
    endfunction

    function automatic int case_len(input int kind, input int gap);
        int rows;
        rows = (kind != 0) ? v_act : v_act / 2;
        return gap + 2 + rows * (4 * h_act + 1);
    endfunction

    // ========================================
    // Reference model, one step per clock
    // ========================================
    always @(posedge clk) begin : model
        vid_out_t exp;
        rgb_t     rd_pix;
        bit       ready, fire, hit, take, de_nx, hs_nx, vs_nx;
        if (!rst_n) begin
            c_phase = 0;
            c_sof   = 0;
            c_done  = 0;
            c_idx   = 0;
            m_valid = 0;
            f_state = s_wait;
            f_bank  = 0;
            f_shown = 0;
            h_cnt   = 0;
            v_cnt   = 0;
            t_de    = 0;
            t_hs    = 0;
            t_vs    = 0;
            t_fs    = 0;
            t_x     = 0;
            t_y     = 0;
            e_de    = 0;
            e_hs    = 0;
            e_vs    = 0;
        end else begin
            cycle_cnt++;
            if (limit > 0 && cycle_cnt > limit)
                abort_run("timeout: the run did not finish within the cycle limit");
            exp.de  = e_de;
            exp.hs  = e_hs;
            exp.vs  = e_vs;
            exp.rgb = (e_de && f_shown) ? e_rgb : '0;   // Black until the first swap
            check_sync(exp, vid);
            check_rgb("vid.rgb", exp.rgb, vid.rgb);
            rd_pix = mbank[~f_bank][t_y * h_act + t_x]; // Read sees the old contents
            // Capture FSM drops any pixel that meets not ready
            ready = (f_state == s_wait) ? (m_valid && m_sof) : (f_state == s_fill);
            fire  = m_valid && ready;
            if (fire) begin
                mbank[f_bank][m_addr] = m_rgb;
                if (m_sof)
                    f_fill_id = m_id;
            end
            case (f_state)
                s_wait: if (fire) f_state = m_eof ? s_full : s_fill;
                s_fill: if (fire && m_eof) f_state = s_full;
                default: begin
                    if (t_fs) begin
                        f_bank  = ~f_bank;              // Completed frame goes to display
                        f_shown = 1;
                        f_state = s_wait;
                        seen[f_fill_id] = 1;
                        swaps++;
                    end
                end
            endcase
            // Display timing
            de_nx = (h_cnt < h_act) && (v_cnt < v_act);
            hs_nx = (h_cnt >= h_act + h_fp) && (h_cnt < h_act + h_fp + h_sync);
            vs_nx = (v_cnt >= v_act + v_fp) && (v_cnt < v_act + v_fp + v_sync);
            e_de  = t_de;
            e_hs  = t_hs;
            e_vs  = t_vs;
            e_rgb = rd_pix;
            t_fs  = vs_nx && !t_vs;
            if (t_fs) fs_count++;
            t_de  = de_nx;
            t_hs  = hs_nx;
            t_vs  = vs_nx;
            t_x   = de_nx ? h_cnt : 0;
            t_y   = de_nx ? v_cnt : 0;
            if (h_cnt == h_total - 1) begin
                h_cnt = 0;
                v_cnt = (v_cnt == v_total - 1) ? 0 : v_cnt + 1;
            end else begin
                h_cnt++;
            end
            // Camera byte pairing
            if (cam.vsync) begin
                c_phase = 0;
                c_idx   = 0;
                c_sof   = 1;
                c_done  = 0;
                m_valid = 0;
                cap_id  = drv_case;
            end else begin
                hit     = cam.href && cam.byte_en;
                take    = hit && c_phase;
                m_valid = take && !c_done;
                if (take) begin
                    m_rgb  = expand565(c_hi, cam.data);
                    m_addr = c_idx;
                    m_sof  = c_sof;
                    m_eof  = (c_idx == frame_px - 1);
                    m_id   = cap_id;
                end
                if (take && !c_done) begin
                    c_done = (c_idx == frame_px - 1);   // Extra pixels are not emitted
                    c_idx++;
                    c_sof  = 0;
                end
                if (hit && !c_phase) c_hi = cam.data;
                if (hit) c_phase = !c_phase;
            end
        end
    end

    // ========================================
    // Camera stimulus
    // ========================================
    task automatic drive_cycle(input logic vs, input logic href, input logic be,
                               input logic [7:0] data);
        @(posedge clk);
        cam <= '{vsync: vs, href: href, byte_en: be, data: data};
    endtask

    task automatic send_frame(input int kind, input int id);
        int rows;
        rows = (kind != 0) ? v_act : v_act / 2;     // Truncated frames stop halfway
        @(posedge clk);
        cam      <= '{vsync: 1'b1, href: 1'b0, byte_en: 1'b0, data: 8'h00};
        drv_case <= id;
        drive_cycle(1'b1, 1'b0, 1'b0, 8'h00);
        for (int r = 0; r < rows; r++) begin
            for (int b = 0; b < 2 * h_act; b++) begin
                drive_cycle(1'b0, 1'b1, 1'b1, 8'($random(seed)));
                drive_cycle(1'b0, 1'b1, 1'b0, 8'h00);
            end
            drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);     // Gap between rows
        end
    endtask

    initial begin : stimulus
        int n_shown;
        int flag_err;
        int fs_mark;
        seed      = 32'ha212;
        rst_n     = 1'b0;
        cam       = '0;
        drv_case  = 0;
        limit     = 0;
        cycle_cnt = 0;
        swaps     = 0;
        fs_count  = 0;
        n_shown   = 0;
        flag_err  = 0;
        for (int i = 0; i < 3 * max_cases; i++)
            cases[i] = 16'hffff;                    // End marker
        $readmemh("verif/cam_cases.txt", cases);
        n_cases = 0;
        while (n_cases < max_cases && cases[3*n_cases] != 16'hffff) begin
            limit += case_len(cases[3*n_cases], cases[3*n_cases+1]) + 3 * h_total * v_total;
            n_shown += (cases[3*n_cases+2] != 0) ? 1 : 0;
            n_cases++;
        end
        limit *= 2;
        if (n_cases == 0)
            abort_run("no cases found in verif/cam_cases.txt");
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            repeat (cases[3*i+1]) drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
            send_frame(cases[3*i], i);
        end
        wait (swaps >= n_shown);
        fs_mark = fs_count;
        wait (fs_count >= fs_mark + 2);             // Scan out the last frame in full
        for (int i = 0; i < n_cases; i++) begin
            if (seen[i] != (cases[3*i+2] != 0)) begin
                $display("case %0d shown=%0d, case file expects %0d",
                         i, seen[i], cases[3*i+2]);
                flag_err++;
            end
        end
        if (flag_err != 0) begin
            abort_run("the frames that reached the display differ from the case file");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== verif/cam_cases.txt ====
// Columns: kind (1 full, 0 truncated), gap before the frame in cycles (hex),
// shown flag (1 when the frame must reach the display)
1 28 1
0 46 0
1 03 1
1 00 0
1 28 1
0 02 0
1 3c 1

// ==== sim.f ====
common/vid_pkg.sv
design/cam_capture.sv
design/frame_ctrl.sv
display/video_timing.sv
frame_buffer/frame_buffer.sv
design/img_cap_top.sv
verif/img_cap_asserts.sv
verif/img_cap_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module img_cap_tb -f sim.f \
    --Mdir obj_dir -o img_cap_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/img_cap_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL: no result line"; exit 1; }
